//--- logic/midi_synth_pkg.sv
// shared constants, envelope states and pitch table; imported by the synth voice modules
package midi_synth_pkg;

    typedef enum logic [1:0] {
        ENV_OFF     = 2'd0,
        ENV_ATTACK  = 2'd1,
        ENV_HOLD    = 2'd2,
        ENV_RELEASE = 2'd3
    } env_state_t;

    // playable note range
    localparam logic [6:0] NOTE_MIN = 7'd29;
    localparam logic [6:0] NOTE_MAX = 7'd91;

    // pedal counts as down from this value up
    localparam logic [7:0] SUS_MIN = 8'd64;

    localparam logic [7:0] MIN_GAIN = 8'd0;
    localparam logic [7:0] MAX_GAIN = 8'd128;

    localparam logic [6:0] SUSTAIN_CC = 7'd64;

    // zero marks an idle or out-of-range note
    typedef logic [5:0] note_index_t;

    function automatic note_index_t note_to_index(input logic [6:0] midi_note);
        logic [6:0] offset;
        offset = midi_note - NOTE_MIN + 7'd1;
        if (midi_note < NOTE_MIN || midi_note > NOTE_MAX) begin
            return '0;
        end
        return offset[5:0];
    endfunction

    // phase steps for F1 up to E2, doubled per octave by the oscillator
    localparam logic [23:0] SEMITONE_INC [12] = '{
        24'd15257, 24'd16164, 24'd17125, 24'd18143,
        24'd19222, 24'd20365, 24'd21576, 24'd22859,
        24'd24218, 24'd25658, 24'd27184, 24'd28800
    };

endpackage

//--- logic/midi_byte_parser.sv
// decodes a strobed MIDI byte stream on channel 0 into note and controller event pulses
module midi_byte_parser (
    input  logic        clk,
    input  logic        reset,
    input  logic [7:0]  midi_byte,
    input  logic        midi_valid,
    output logic        note_event,
    output logic        controller_event,
    output logic [13:0] note_values,
    output logic [13:0] controller_values
);

    logic [7:0] status;
    logic       have_first;
    logic [6:0] first_byte;
    logic       status_byte;
    logic       data_byte;
    logic       pair_done;
    logic       accept_status;

    assign status_byte = midi_valid && midi_byte[7];
    assign data_byte   = midi_valid && !midi_byte[7] && (status != 8'h00);
    assign pair_done   = data_byte && have_first;

    // note off, note on and control change on channel 0 only
    assign accept_status = (midi_byte == 8'h80) || (midi_byte == 8'h90) ||
                           (midi_byte == 8'hB0);

    always_ff @(posedge clk) begin
        if (reset) begin
            status           <= 8'h00;
            have_first       <= 1'b0;
            note_event       <= 1'b0;
            controller_event <= 1'b0;
        end else begin
            note_event       <= pair_done && (status != 8'hB0);
            controller_event <= pair_done && (status == 8'hB0);
            // real-time bytes leave running status alone
            if (status_byte && midi_byte < 8'hF8) begin
                status     <= accept_status ? midi_byte : 8'h00;
                have_first <= 1'b0;
            end else if (data_byte) begin
                have_first <= !have_first;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_byte && !have_first) begin
            first_byte <= midi_byte[6:0];
        end
        if (pair_done) begin
            case (status)
                8'h80: note_values <= {7'd0, first_byte};
                8'h90: note_values <= {midi_byte[6:0], first_byte};
                default: controller_values <= {midi_byte[6:0], first_byte};
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        !(note_event && controller_event))
        else $error("note and controller events collided");

endmodule

//--- logic/voice_allocator.sv
// steers note events to free or matching voices and broadcasts controller events
module voice_allocator #(
    parameter int NUM_VOICES = 4
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         note_event,
    input  logic                                         controller_event,
    input  logic [13:0]                                  note_values,
    input  logic [13:0]                                  controller_values,
    input  logic [NUM_VOICES-1:0]                        voice_on,
    input  midi_synth_pkg::note_index_t [NUM_VOICES-1:0] voice_note,
    output logic [NUM_VOICES-1:0]                        update_voice,
    output logic                                         update_all_voices,
    output logic [13:0]                                  voice_note_values,
    output logic [13:0]                                  voice_controller_values
);

    import midi_synth_pkg::*;

    note_index_t           event_index;
    logic                  note_on;
    logic                  note_off;
    logic                  found;
    logic [NUM_VOICES-1:0] target;

    assign event_index = note_to_index(note_values[6:0]);
    assign note_on  = note_event && (note_values[13:7] != 7'd0) && (event_index != '0);
    assign note_off = note_event && (note_values[13:7] == 7'd0) && (event_index != '0);

    always_comb begin
        target = '0;
        found  = 1'b0;
        // lowest idle voice, skipping one handed a note last cycle
        for (int v = 0; v < NUM_VOICES; v++) begin
            if (note_on && !found && !voice_on[v] && !update_voice[v]) begin
                target[v] = 1'b1;
                found     = 1'b1;
            end
        end
        for (int v = 0; v < NUM_VOICES; v++) begin
            if (note_off && voice_on[v] && (voice_note[v] == event_index)) begin
                target[v] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            update_voice      <= '0;
            update_all_voices <= 1'b0;
        end else begin
            update_voice      <= target;
            update_all_voices <= controller_event;
        end
    end

    always_ff @(posedge clk) begin
        voice_note_values       <= note_values;
        voice_controller_values <= controller_values;
    end

    assert property (@(posedge clk) disable iff (reset)
        note_on |=> $onehot0(update_voice))
        else $error("note-on assigned to more than one voice");

endmodule

//--- logic/harmonic_dynamics.sv
// per-voice envelope; steps the gain at sample zero crossings through attack, hold, release
module harmonic_dynamics #(
    parameter int ATTACK_TIME  = 75,
    parameter int SUSTAIN_TIME = 1400,
    parameter int REL_TIME     = 150
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        update_voice,
    input  logic                        update_all_voices,
    input  logic [13:0]                 controller_values,
    input  logic [13:0]                 note_values,
    input  logic                        generate_next,
    input  logic [15:0]                 sustain_inc,
    input  logic signed [15:0]          sample_in,
    output logic                        voice_on,
    output midi_synth_pkg::note_index_t note,
    output logic [7:0]                  velocity,
    output logic [7:0]                  gain,
    output logic                        decay_type
);

    import midi_synth_pkg::*;

    env_state_t         state;
    logic [15:0]        count;
    logic [15:0]        sustain;
    logic [7:0]         pedal;
    logic signed [15:0] prev_sample;
    logic               zero_crossing;
    logic               key_down;
    logic               key_up;
    logic               release_due;

    assign voice_on      = (state != ENV_OFF);
    assign decay_type    = (state != ENV_ATTACK);
    assign sustain       = 16'(SUSTAIN_TIME) + sustain_inc;
    assign zero_crossing = (prev_sample[15] != sample_in[15]);
    assign key_down      = update_voice && (note_values[13:7] != 7'd0);
    assign key_up        = update_voice && (note_values[13:7] == 7'd0);

    // pedal down stretches the release to the sustain time
    assign release_due = (pedal >= SUS_MIN) ? (count >= sustain) : (count >= 16'(REL_TIME));

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ENV_OFF;
            count    <= '0;
            gain     <= MIN_GAIN;
            note     <= '0;
            velocity <= '0;
        end else begin
            case (state)
                ENV_OFF: begin
                    count <= '0;
                    gain  <= MIN_GAIN;
                    if (key_down) begin
                        state    <= ENV_ATTACK;
                        velocity <= {1'b0, note_values[13:7]};
                        note     <= note_to_index(note_values[6:0]);
                    end else begin
                        velocity <= '0;
                        note     <= '0;
                    end
                end
                ENV_ATTACK: begin
                    if (generate_next) begin
                        count <= count + 16'd1;
                    end else if (count >= 16'(ATTACK_TIME) && zero_crossing) begin
                        count <= '0;
                        if (gain == MAX_GAIN) begin
                            state <= ENV_HOLD;
                        end else begin
                            gain <= gain + 8'd1;
                        end
                    end
                end
                ENV_HOLD: begin
                    if (key_up) begin
                        count <= '0;
                        state <= ENV_RELEASE;
                    end else if (generate_next) begin
                        count <= count + 16'd1;
                    end else if (count >= sustain && zero_crossing) begin
                        count <= '0;
                        if (gain != MIN_GAIN) begin
                            gain <= gain - 8'd1;
                        end
                    end
                end
                ENV_RELEASE: begin
                    if (gain == MIN_GAIN) begin
                        state <= ENV_OFF;
                    end else if (generate_next) begin
                        count <= count + 16'd1;
                    end else if (release_due && zero_crossing) begin
                        count <= '0;
                        gain  <= gain - 8'd1;
                    end
                end
                default: state <= ENV_OFF;
            endcase
        end
    end

    // pedal level and sample sign history
    always_ff @(posedge clk) begin
        if (reset) begin
            pedal       <= '0;
            prev_sample <= '0;
        end else begin
            if (update_all_voices && controller_values[6:0] == SUSTAIN_CC) begin
                pedal <= {1'b0, controller_values[13:7]};
            end
            if (generate_next) begin
                prev_sample <= sample_in;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) gain <= MAX_GAIN)
        else $error("gain above full scale");

endmodule

//--- logic/voice_oscillator.sv
// per-voice sawtooth oscillator; a phase accumulator stepped once per sample tick
module voice_oscillator (
    input  logic                        clk,
    input  logic                        reset,
    input  midi_synth_pkg::note_index_t note,
    input  logic                        generate_next,
    output logic signed [15:0]          sample
);

    import midi_synth_pkg::*;

    logic [23:0] phase;
    logic [5:0]  offset;
    logic [3:0]  semitone;
    logic [2:0]  octave;
    logic [23:0] inc;

    // split index into semitone and octave above F1
    assign offset   = note - 6'd1;
    assign semitone = 4'(offset % 6'd12);
    assign octave   = 3'(offset / 6'd12);
    assign inc      = SEMITONE_INC[semitone] << octave;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= '0;
        end else if (generate_next) begin
            if (note == '0) begin
                phase <= '0;
            end else begin
                phase <= phase + inc;
            end
        end
    end

    // centre the ramp around zero
    assign sample = $signed(phase[23:8] - 16'h8000);

endmodule

//--- logic/voice_mixer.sv
// sample tick generator and gain-weighted sum of all voice samples
module voice_mixer #(
    parameter int NUM_VOICES    = 4,
    parameter int SAMPLE_DIVIDE = 1024
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [NUM_VOICES-1:0][15:0]  voice_sample,
    input  logic [NUM_VOICES-1:0][7:0]   voice_gain,
    output logic                         generate_next,
    output logic signed [15:0]           mix_sample,
    output logic                         mix_valid
);

    localparam int DIV_W = $clog2(SAMPLE_DIVIDE + 1);

    logic [DIV_W-1:0]   div_count;
    logic signed [31:0] acc;

    always_ff @(posedge clk) begin
        if (reset) begin
            div_count     <= '0;
            generate_next <= 1'b0;
        end else begin
            generate_next <= (div_count == DIV_W'(SAMPLE_DIVIDE - 1));
            if (div_count == DIV_W'(SAMPLE_DIVIDE - 1)) begin
                div_count <= '0;
            end else begin
                div_count <= div_count + 1'b1;
            end
        end
    end

    // gain 128 is unity, so each product drops 7 bits
    always_comb begin
        acc = '0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            acc += ($signed(voice_sample[v]) * $signed({1'b0, voice_gain[v]})) >>> 7;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mix_sample <= '0;
            mix_valid  <= 1'b0;
        end else begin
            mix_valid <= generate_next;
            if (generate_next) begin
                if (acc > 32'sd32767) begin
                    mix_sample <= 16'sh7fff;
                end else if (acc < -32'sd32768) begin
                    mix_sample <= 16'sh8000;
                end else begin
                    mix_sample <= acc[15:0];
                end
            end
        end
    end

endmodule

//--- logic/midi_synth_top.sv
// top of the voice section; MIDI bytes in, mixed audio samples and voice status out
module midi_synth_top #(
    parameter int NUM_VOICES    = 4,
    parameter int ATTACK_TIME   = 75,
    parameter int SUSTAIN_TIME  = 1400,
    parameter int REL_TIME      = 150,
    parameter int SAMPLE_DIVIDE = 1024
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [7:0]                  midi_byte,
    input  logic                        midi_valid,
    input  logic [15:0]                 sustain_inc,
    output logic signed [15:0]          mix_sample,
    output logic                        mix_valid,
    output logic [NUM_VOICES-1:0]       voice_on,
    output logic [NUM_VOICES-1:0][7:0]  voice_gain
);

    import midi_synth_pkg::*;

    logic                             note_event;
    logic                             controller_event;
    logic [13:0]                      note_values;
    logic [13:0]                      controller_values;
    logic [NUM_VOICES-1:0]            update_voice;
    logic                             update_all_voices;
    logic [13:0]                      voice_note_values;
    logic [13:0]                      voice_controller_values;
    logic                             generate_next;
    note_index_t [NUM_VOICES-1:0]     voice_note;
    logic [NUM_VOICES-1:0][15:0]      voice_sample;

    midi_byte_parser parser_i (
        .clk, .reset, .midi_byte, .midi_valid,
        .note_event, .controller_event, .note_values, .controller_values
    );

    voice_allocator #(.NUM_VOICES(NUM_VOICES)) allocator_i (
        .clk, .reset, .note_event, .controller_event, .note_values, .controller_values,
        .voice_on, .voice_note, .update_voice, .update_all_voices,
        .voice_note_values, .voice_controller_values
    );

    for (genvar v = 0; v < NUM_VOICES; v++) begin : g_voice
        harmonic_dynamics #(
            .ATTACK_TIME(ATTACK_TIME), .SUSTAIN_TIME(SUSTAIN_TIME), .REL_TIME(REL_TIME)
        ) envelope_i (
            .clk, .reset,
            .update_voice(update_voice[v]), .update_all_voices,
            .controller_values(voice_controller_values), .note_values(voice_note_values),
            .generate_next, .sustain_inc, .sample_in(voice_sample[v]),
            .voice_on(voice_on[v]), .note(voice_note[v]), .velocity(),
            .gain(voice_gain[v]), .decay_type()
        );

        voice_oscillator osc_i (
            .clk, .reset, .note(voice_note[v]), .generate_next, .sample(voice_sample[v])
        );
    end

    voice_mixer #(.NUM_VOICES(NUM_VOICES), .SAMPLE_DIVIDE(SAMPLE_DIVIDE)) mixer_i (
        .clk, .reset, .voice_sample, .voice_gain, .generate_next, .mix_sample, .mix_valid
    );

endmodule

//--- bench/midi_synth_tb.sv
// testbench for midi_synth_top; plays MIDI messages and checks voice allocation and envelopes
module midi_synth_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NV            = 4;
    localparam int SAMPLE_DIVIDE = 4;
    localparam int SUSTAIN_TIME  = 4;
    localparam int SUS_INC       = 64;
    localparam int FULL_GAIN     = 128;
    // slowest gain step is the pedal count limit plus half a period of the lowest test note
    localparam int STEP_TICKS    = SUSTAIN_TIME + SUS_INC + 64;
    localparam int ENV_CYCLES    = 2 * (FULL_GAIN + 2) * STEP_TICKS * SAMPLE_DIVIDE;
    localparam int NUM_TESTS     = 7;

    logic                  clk;
    logic                  reset;
    logic [7:0]            midi_byte;
    logic                  midi_valid;
    logic [15:0]           sustain_inc;
    logic signed [15:0]    mix_sample;
    logic                  mix_valid;
    logic [NV-1:0]         voice_on;
    logic [NV-1:0][7:0]    voice_gain;

    logic [31:0]   lfsr = 32'h22f4_b4f6;
    logic [NV-1:0] model_on;
    logic [5:0]    model_idx [NV];
    logic [NV-1:0] exp_on;
    event          compare_ev;
    int            errors;
    int            test_errors;
    int            checks;
    int            tests;
    int            since_valid;
    int            mix_pulses;
    int            loud_mixes;
    int            gain_bound;

    midi_synth_top #(
        .NUM_VOICES(NV), .ATTACK_TIME(2), .SUSTAIN_TIME(SUSTAIN_TIME), .REL_TIME(1),
        .SAMPLE_DIVIDE(SAMPLE_DIVIDE)
    ) dut_i (
        .clk, .reset, .midi_byte, .midi_valid, .sustain_inc,
        .mix_sample, .mix_valid, .voice_on, .voice_gain
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * ENV_CYCLES * 8);
        $display("watchdog expired after %0d cycles, a voice is stuck", NUM_TESTS * ENV_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // voice state checker
    always @(compare_ev) begin
        checks++;
        if (voice_on !== exp_on) begin
            $display("FAILED voice_on: expected %h, got %h", exp_on, voice_on);
            errors++;
            test_errors++;
        end
    end

    // mix_valid cadence and a mix no louder than the previous gains allow
    always @(negedge clk) begin
        int mag;
        since_valid++;
        if (mix_valid) begin
            checks++;
            if (mix_pulses > 0 && since_valid != SAMPLE_DIVIDE) begin
                $display("FAILED mix_valid spacing: expected %h, got %h",
                         SAMPLE_DIVIDE, since_valid);
                record_error();
            end
            mag = (mix_sample < 0) ? -int'(mix_sample) : int'(mix_sample);
            if (mag > gain_bound) begin
                $display("FAILED mix_sample: expected magnitude at most %h, got %h",
                         gain_bound, mix_sample);
                record_error();
            end
            if (mix_sample != 16'sd0) begin
                loud_mixes++;
            end
            mix_pulses++;
            since_valid = 0;
        end
        // full scale sample times gain, shifted right by 7
        gain_bound = 0;
        for (int v = 0; v < NV; v++) begin
            gain_bound += 256 * int'(voice_gain[v]);
        end
    end

    function automatic logic [5:0] index_of(input logic [6:0] note);
        if (note < 7'd29 || note > 7'd91) begin
            return 6'd0;
        end
        return 6'(note - 7'd28);
    endfunction

    // lowest free voice takes a playable note-on and -1 means none does
    function automatic int pick_voice(input logic [NV-1:0] on, input logic [6:0] note);
        if (index_of(note) == 6'd0) begin
            return -1;
        end
        for (int v = 0; v < NV; v++) begin
            if (!on[v]) begin
                return v;
            end
        end
        return -1;
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic record_error();
        errors++;
        test_errors++;
    endtask

    task automatic send_byte(input logic [7:0] b);
        midi_byte  = b;
        midi_valid = 1'b1;
        @(negedge clk);
        midi_valid = 1'b0;
    endtask

    task automatic compare_voices();
        exp_on = model_on;
        -> compare_ev;
        @(negedge clk);
    endtask

    task automatic note_on(input logic [6:0] note, input logic [6:0] vel);
        int v;
        int lat;
        v = pick_voice(model_on, note);
        send_byte(8'h90);
        send_byte({1'b0, note});
        send_byte({1'b0, vel});
        lat = 1;
        if (v >= 0) begin
            model_on[v]  = 1'b1;
            model_idx[v] = index_of(note);
            while (!voice_on[v] && lat < 8) begin
                @(negedge clk);
                lat++;
            end
            checks++;
            if (lat != 3) begin
                $display("FAILED voice_on[%0d] latency: expected %0h, got %0h", v, 3, lat);
                record_error();
            end
        end else begin
            repeat (8) @(negedge clk);
        end
        compare_voices();
    endtask

    // gain must climb to full scale, then the first hold step marks the hold state
    task automatic attack_to_hold(input int v);
        logic [7:0] last;
        int         n;
        last = 8'd0;
        n    = 0;
        while (voice_gain[v] != 8'(FULL_GAIN) && n < ENV_CYCLES) begin
            @(negedge clk);
            n++;
            if (voice_gain[v] < last) begin
                $display("FAILED voice_gain[%0d]: %h after %h in attack", v, voice_gain[v], last);
                record_error();
            end
            last = voice_gain[v];
        end
        checks++;
        if (voice_gain[v] != 8'(FULL_GAIN)) begin
            $display("voice %0d did not reach full gain within %0d cycles", v, ENV_CYCLES);
            record_error();
        end
        while (voice_gain[v] == 8'(FULL_GAIN) && n < ENV_CYCLES) begin
            @(negedge clk);
            n++;
        end
    endtask

    task automatic release_note(input logic [6:0] note, input logic running, output int cycles);
        logic [NV-1:0] hit;
        hit = '0;
        for (int v = 0; v < NV; v++) begin
            if (model_on[v] && model_idx[v] == index_of(note)) begin
                hit[v] = 1'b1;
            end
        end
        if (running) begin
            send_byte({1'b0, note});
            send_byte(8'h00);
        end else begin
            send_byte(8'h80);
            send_byte({1'b0, note});
            send_byte(8'h40);
        end
        cycles = 1;
        while ((voice_on & hit) != '0 && cycles < ENV_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if ((voice_on & hit) != '0) begin
            $display("released voice still on after %0d cycles", ENV_CYCLES);
            record_error();
        end
        for (int v = 0; v < NV; v++) begin
            if (hit[v]) begin
                checks++;
                if (voice_gain[v] != 8'd0) begin
                    $display("FAILED voice_gain[%0d]: expected 00, got %h", v, voice_gain[v]);
                    record_error();
                end
            end
        end
        model_on = model_on & ~hit;
        compare_voices();
    endtask

    task automatic end_test(input string name);
        tests++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        logic [6:0] note_a;
        logic [6:0] note_b;
        logic [6:0] vel;
        int         bits;
        int         rel_up;
        int         rel_down;
        int         rel_run;
        midi_byte   = 8'h00;
        midi_valid  = 1'b0;
        sustain_inc = 16'(SUS_INC);
        model_on    = '0;
        reset       = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        take_bits(4, bits);
        note_a = 7'(80 + bits % 12);
        take_bits(7, bits);
        vel = 7'(1 + bits % 127);
        note_on(note_a, vel);
        end_test("note-on latency");
        attack_to_hold(0);
        end_test("attack gain");

        release_note(note_a, 1'b0, rel_up);
        take_bits(4, bits);
        note_b = 7'(80 + bits % 12);
        note_on(note_b, vel);
        attack_to_hold(0);
        release_note(note_b, 1'b1, rel_run);
        end_test("note release");

        // pedal down, same note as the pedal-up release
        send_byte(8'hB0);
        send_byte(8'h40);
        send_byte(8'h7F);
        note_on(note_a, vel);
        attack_to_hold(0);
        release_note(note_a, 1'b0, rel_down);
        send_byte(8'hB0);
        send_byte(8'h40);
        send_byte(8'h00);
        checks++;
        if (rel_down <= rel_up || rel_down <= rel_run) begin
            $display("pedal-down release took %0d cycles, not longer than %0d and %0d",
                     rel_down, rel_up, rel_run);
            record_error();
        end
        end_test("sustain pedal");

        send_byte(8'h91);
        send_byte({1'b0, note_b});
        send_byte(8'h60);
        send_byte(8'hB1);
        send_byte(8'h40);
        send_byte(8'h7F);
        repeat (8) @(negedge clk);
        compare_voices();
        end_test("channel filter");

        // fifth note-on finds every voice busy
        for (int i = 0; i < NV + 1; i++) begin
            take_bits(4, bits);
            note_b = 7'(80 + bits % 12);
            take_bits(7, bits);
            note_on(note_b, 7'(1 + bits % 127));
        end
        end_test("voice allocation");

        checks++;
        if (loud_mixes == 0) begin
            $display("mix_sample stayed at zero while voices were sounding");
            record_error();
        end
        end_test("mixer output");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- midi_synth.f
logic/midi_synth_pkg.sv
logic/midi_byte_parser.sv
logic/voice_allocator.sv
logic/harmonic_dynamics.sv
logic/voice_oscillator.sv
logic/voice_mixer.sv
logic/midi_synth_top.sv
bench/midi_synth_tb.sv
